//--- all.f
logic/ff_train_pkg.sv
logic/sample_loader.sv
logic/forward_sequencer.sv
logic/layer_mailbox.sv
logic/update_sequencer.sv
logic/training_controller.sv
dv/tb_models.sv
dv/tb_training_controller.sv

//--- dv/tb_models.sv
//////////////////////////////
// Testbench models for memories, layer units and
// plasticity engine with random latencies
//////////////////////////////
module tb_models (
    input  logic                       clk,
    input  ff_train_pkg::sample_addr_t sample_addr,
    input  logic                       sample_en,
    output ff_train_pkg::data_t        sample_rdata,
    input  ff_train_pkg::sample_idx_t  label_addr,
    input  logic                       label_en,
    output ff_train_pkg::label_t       label_rdata,
    input  ff_train_pkg::layer_req_t   l1_req,
    input  ff_train_pkg::layer_req_t   l2_req,
    output ff_train_pkg::layer_rsp_t   l1_rsp,
    output ff_train_pkg::layer_rsp_t   l2_rsp,
    input  ff_train_pkg::pe_cmd_t      pe_cmd,
    output logic                       pe_done
);
    timeunit 1ns;
    timeprecision 1ps;
    import ff_train_pkg::*;

    logic [15:0] lfsr = 16'd35120;
    data_t       sample_q = '0;
    label_t      label_q = '0;
    logic        pe_q = 1'b0;
    layer_rsp_t  rsp_q [2] = '{default: '0};
    layer_req_t  req [2];
    // Remaining cycles of the MAC or RN step, 0 when idle
    int          op_wait [2] = '{0, 0};
    logic        op_mac [2] = '{1'b0, 1'b0};
    int          good_wait [2] = '{0, 0};
    int          good_count [2] = '{0, 0};
    int          pe_wait = 0;

    assign req[0]       = l1_req;
    assign req[1]       = l2_req;
    assign sample_rdata = sample_q;
    assign label_rdata  = label_q;
    assign l1_rsp       = rsp_q[0];
    assign l2_rsp       = rsp_q[1];
    assign pe_done      = pe_q;

    // Taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Six bits per draw, mapped onto 2 to 40 cycles
    task automatic draw_latency(output int lat);
        logic [5:0] bits;
        bits = '0;
        for (int b = 0; b < 6; b++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[4:0], lfsr[0]};
        end
        lat = 2 + int'(bits) % 39;
    endtask

    always @(posedge clk) begin
        int lat;
        // Pixel value is sample * 256 + pixel
        if (sample_en)
            sample_q <= data_t'(int'(sample_addr) / INPUT_SIZE * 256
                                + int'(sample_addr) % INPUT_SIZE);
        if (label_en)
            label_q <= label_t'(int'(label_addr) * 3 % LABEL_PIXELS);
        for (int i = 0; i < 2; i++) begin
            rsp_q[i].mac_done      <= 1'b0;
            rsp_q[i].rn_done       <= 1'b0;
            rsp_q[i].goodness_done <= 1'b0;
            if (req[i].mac_start || req[i].rn_start) begin
                draw_latency(lat);
                op_wait[i] = lat;
                op_mac[i]  = req[i].mac_start;
            end else if (op_wait[i] == 1) begin
                op_wait[i] = 0;
                rsp_q[i].mac_done <= op_mac[i];
                rsp_q[i].rn_done  <= !op_mac[i];
            end else if (op_wait[i] > 1) begin
                op_wait[i]--;
            end
            // Goodness is layer number * 65536 plus the count of earlier starts
            if (req[i].goodness_start) begin
                draw_latency(lat);
                good_wait[i] = lat;
                rsp_q[i].goodness_val <= data_t'((i + 1) * 65536 + good_count[i]);
                good_count[i]++;
            end else if (good_wait[i] == 1) begin
                good_wait[i] = 0;
                rsp_q[i].goodness_done <= 1'b1;
            end else if (good_wait[i] > 1) begin
                good_wait[i]--;
            end
        end
        pe_q <= 1'b0;
        if (pe_cmd.start) begin
            draw_latency(lat);
            pe_wait = lat;
        end else if (pe_wait == 1) begin
            pe_wait = 0;
            pe_q <= 1'b1;
        end else if (pe_wait > 1) begin
            pe_wait--;
        end
    end

endmodule

//--- dv/tb_training_controller.sv
//////////////////////////////
// Training controller testbench with scoreboard assertions
//////////////////////////////
module tb_training_controller;
    timeunit 1ns;
    timeprecision 1ps;
    import ff_train_pkg::*;

    localparam int TIMEOUT_CYCLES = 100000;
    localparam int NUM_CMDS       = 4 * NUM_SAMPLES;

    logic         clk = 1'b0;
    logic         rst_n = 1'b0;
    logic         start = 1'b0;
    logic         training_done;
    sample_addr_t sample_addr;
    logic         sample_en;
    data_t        sample_rdata;
    sample_idx_t  label_addr;
    logic         label_en;
    label_t       label_rdata;
    pixel_idx_t   inbuf_waddr;
    logic         inbuf_we;
    data_t        inbuf_wdata;
    label_t       correct_label;
    label_t       injected_label;
    logic         input_shadow_capture;
    logic         inject_en;
    layer_req_t   l1_req;
    layer_req_t   l2_req;
    layer_rsp_t   l1_rsp;
    layer_rsp_t   l2_rsp;
    pe_cmd_t      pe_cmd;
    logic         pe_done;

    // Scoreboard state
    logic  started = 1'b0;
    logic  quiet;
    data_t inbuf_mirror [INPUT_SIZE];
    logic  inject_q = 1'b0;
    logic  l1_rn_seen = 1'b0;
    logic  l2_rn_seen = 1'b0;
    int    load_count = 0;
    int    cmd_count = 0;
    int    done_count = 0;

    training_controller dut (.*);
    tb_models models (.*);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    // Labels and buffer contents of the pass that just finished loading
    task automatic check_load();
        int     s;
        label_t good_label;
        label_t exp_label;
        s          = load_count / 2;
        good_label = label_t'(s * 3 % LABEL_PIXELS);
        exp_label  = (load_count % 2 == 0) ? good_label
                   : label_t'((int'(good_label) + 1) % LABEL_PIXELS);
        assert (load_count < 2 * NUM_SAMPLES) else report_error("extra sample load");
        assert (correct_label == good_label) else report_error($sformatf(
            "correct_label %0d, expected %0d", correct_label, good_label));
        assert (injected_label == exp_label) else report_error($sformatf(
            "injected_label %0d, expected %0d", injected_label, exp_label));
        for (int w = 0; w < LABEL_PIXELS; w++)
            assert (inbuf_mirror[w] == ((w == int'(exp_label)) ? LABEL_MAG : '0))
                else report_error($sformatf("label word %0d is %h", w, inbuf_mirror[w]));
        for (int w = LABEL_PIXELS; w < INPUT_SIZE; w++)
            assert (inbuf_mirror[w] == data_t'(s * 256 + w))
                else report_error($sformatf("pixel word %0d is %h", w, inbuf_mirror[w]));
    endtask

    // Order is L1 pos, L2 pos, L1 neg, L2 neg per sample
    task automatic check_command();
        int    s;
        int    r;
        logic  layer;
        logic  pos;
        data_t exp_good;
        s        = cmd_count / 4;
        r        = cmd_count % 4;
        layer    = (r % 2) == 1;
        pos      = r < 2;
        exp_good = data_t'((int'(layer) + 1) * 65536 + 2 * s + (pos ? 0 : 1));
        assert (cmd_count < NUM_CMDS) else report_error("extra plasticity command");
        assert (pe_cmd.layer_sel == layer && pe_cmd.is_positive == pos)
            else report_error($sformatf("command %0d has layer %0d positive %0d",
                                        cmd_count, pe_cmd.layer_sel, pe_cmd.is_positive));
        assert (pe_cmd.goodness == exp_good) else report_error($sformatf(
            "command %0d goodness %h, expected %h", cmd_count, pe_cmd.goodness, exp_good));
    endtask

    assign quiet = l1_req == '0 && l2_req == '0 && !inbuf_we && !input_shadow_capture
                && !inject_en && !pe_cmd.start && !training_done;

    always @(posedge clk) begin
        if (inbuf_we)
            inbuf_mirror[inbuf_waddr] <= inbuf_wdata;
        inject_q <= inject_en;
        if (inject_q) begin
            check_load();
            load_count <= load_count + 1;
        end
        if (pe_cmd.start) begin
            check_command();
            cmd_count <= cmd_count + 1;
        end
        if (training_done)
            done_count <= done_count + 1;
        // RN finished and goodness not yet started
        if (l1_rsp.rn_done)
            l1_rn_seen <= 1'b1;
        else if (l1_req.goodness_start)
            l1_rn_seen <= 1'b0;
        if (l2_rsp.rn_done)
            l2_rn_seen <= 1'b1;
        else if (l2_req.goodness_start)
            l2_rn_seen <= 1'b0;
    end

    a_quiet: assert property (@(posedge clk) !started |-> quiet)
        else report_error("control outputs active before start");
    a_l1_mac: assert property (@(posedge clk) disable iff (!rst_n)
        l1_req.mac_start |-> $past(inject_en))
        else report_error("layer 1 mac_start without a finished load");
    a_l1_rn: assert property (@(posedge clk) disable iff (!rst_n)
        l1_req.rn_start |-> $past(l1_rsp.mac_done))
        else report_error("layer 1 rn_start not after mac_done");
    a_l2_rn: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req.rn_start |-> $past(l2_rsp.mac_done))
        else report_error("layer 2 rn_start not after mac_done");
    a_l1_good: assert property (@(posedge clk) disable iff (!rst_n)
        l1_req.goodness_start |-> l1_rn_seen)
        else report_error("layer 1 goodness_start before rn_done");
    a_l2_good: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req.goodness_start |-> l2_rn_seen)
        else report_error("layer 2 goodness_start before rn_done");
    a_l2_mac: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req.mac_start |-> $past(l1_req.goodness_start))
        else report_error("layer 2 mac_start not after layer 1 goodness_start");
    a_capture: assert property (@(posedge clk) disable iff (!rst_n)
        l1_req.shadow_capture == l1_req.goodness_start
        && l2_req.shadow_capture == l2_req.goodness_start
        && input_shadow_capture == inject_en)
        else report_error("capture pulse apart from goodness_start or inject_en");
    a_done: assert property (@(posedge clk) disable iff (!rst_n)
        training_done |-> cmd_count == NUM_CMDS && done_count == 0 && $past(pe_done, 2))
        else report_error("training_done early, repeated or not after the last pe_done");

    initial begin
        int wait_cycles;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        start   <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_cycles = 0;
        while (!training_done) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES)
                abort_run("Timeout while waiting for training_done");
        end
        // Drain so a second done pulse would be seen
        repeat (50) @(posedge clk);
        if (cmd_count == NUM_CMDS && done_count == 1 && load_count == 2 * NUM_SAMPLES) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run($sformatf("Saw %0d loads, %0d plasticity commands and %0d done pulses",
                                load_count, cmd_count, done_count));
        end
    end

endmodule

//--- logic/ff_train_pkg.sv
//////////////////////////////
// Forward-Forward training controller shared sizes, types,
// state encodings and the layer and plasticity bundles
//////////////////////////////
package ff_train_pkg;

    // Dataset kept small for simulation
    localparam int NUM_SAMPLES  = 8;
    localparam int INPUT_SIZE   = 32;
    localparam int LABEL_PIXELS = 10;
    localparam int DATA_WIDTH   = 32;

    // Hot label pixel, 1.0 in Q16.16
    localparam logic [DATA_WIDTH-1:0] LABEL_MAG = 32'h0001_0000;

    // Last cycle of a load, counted from load_start
    localparam int LOAD_LAST = INPUT_SIZE + LABEL_PIXELS;

    localparam int SAMPLE_IDX_W  = $clog2(NUM_SAMPLES);
    localparam int PIXEL_IDX_W   = $clog2(INPUT_SIZE);
    localparam int SAMPLE_ADDR_W = $clog2(NUM_SAMPLES * INPUT_SIZE);
    localparam int LOAD_CNT_W    = $clog2(LOAD_LAST + 1);

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [SAMPLE_IDX_W-1:0]  sample_idx_t;
    typedef logic [PIXEL_IDX_W-1:0]   pixel_idx_t;
    typedef logic [SAMPLE_ADDR_W-1:0] sample_addr_t;
    typedef logic [LOAD_CNT_W-1:0]    load_cnt_t;
    typedef logic [3:0]               label_t;

    // Forward side, one pass per sample and label polarity
    typedef enum logic [3:0] {
        FWD_IDLE, FWD_LOAD, FWD_L1_MAC, FWD_L1_RN, FWD_L1_GOOD,
        FWD_L2_MAC, FWD_L2_RN, FWD_L2_GOOD, FWD_NEXT_PASS, FWD_DONE
    } fwd_state_t;

    // Update side, trails the forward side through the mailbox
    typedef enum logic [2:0] {
        UPD_IDLE, UPD_WAIT_L1, UPD_PE_L1, UPD_WAIT_L2, UPD_PE_L2, UPD_NEXT, UPD_DONE
    } upd_state_t;

    // Sequencer to layer unit, all single-cycle pulses
    typedef struct packed {
        logic mac_start;
        logic rn_start;
        logic shadow_capture;
        logic goodness_start;
    } layer_req_t;

    // Layer unit back to sequencer and mailbox
    typedef struct packed {
        logic  mac_done;
        logic  rn_done;
        logic  goodness_done;
        data_t goodness_val;
    } layer_rsp_t;

    // Plasticity command, layer_sel is 0 for layer 1
    typedef struct packed {
        logic  start;
        logic  layer_sel;
        logic  is_positive;
        data_t goodness;
    } pe_cmd_t;

endpackage

//--- logic/forward_sequencer.sv
//////////////////////////////
// Forward sequencer that runs load, both layers and goodness
// for the positive and negative pass of every sample
//////////////////////////////
module forward_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output logic                      load_start,
    output ff_train_pkg::sample_idx_t sample_idx,
    output logic                      is_positive,
    input  logic                      load_done,
    output ff_train_pkg::layer_req_t  l1_req,
    output ff_train_pkg::layer_req_t  l2_req,
    input  ff_train_pkg::layer_rsp_t  l1_rsp,
    input  ff_train_pkg::layer_rsp_t  l2_rsp,
    input  logic                      l1_full,
    input  logic                      l2_full
);
    import ff_train_pkg::*;

    fwd_state_t state;

    // Registered start pulses
    logic l1_mac_q;
    logic l1_rn_q;
    logic l2_mac_q;
    logic l2_rn_q;

    // Layer 2 goodness issued, now waiting on its done
    logic l2_good_sent;

    // Goodness only goes out while the mailbox entry is free
    logic l1_good_go;
    logic l2_good_go;

    assign l1_good_go = (state == FWD_L1_GOOD) && !l1_full;
    assign l2_good_go = (state == FWD_L2_GOOD) && !l2_good_sent && !l2_full;

    // Shadow capture rides with goodness_start
    always_comb begin
        l1_req = '{mac_start:      l1_mac_q,
                   rn_start:       l1_rn_q,
                   shadow_capture: l1_good_go,
                   goodness_start: l1_good_go};
        l2_req = '{mac_start:      l2_mac_q,
                   rn_start:       l2_rn_q,
                   shadow_capture: l2_good_go,
                   goodness_start: l2_good_go};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= FWD_IDLE;
            sample_idx   <= '0;
            is_positive  <= 1'b1;
            load_start   <= 1'b0;
            l1_mac_q     <= 1'b0;
            l1_rn_q      <= 1'b0;
            l2_mac_q     <= 1'b0;
            l2_rn_q      <= 1'b0;
            l2_good_sent <= 1'b0;
        end else begin
            load_start <= 1'b0;
            l1_mac_q   <= 1'b0;
            l1_rn_q    <= 1'b0;
            l2_mac_q   <= 1'b0;
            l2_rn_q    <= 1'b0;
            case (state)
                FWD_IDLE: begin
                    if (start) begin
                        sample_idx  <= '0;
                        is_positive <= 1'b1;
                        load_start  <= 1'b1;
                        state       <= FWD_LOAD;
                    end
                end
                FWD_LOAD: begin
                    if (load_done) begin
                        l1_mac_q <= 1'b1;
                        state    <= FWD_L1_MAC;
                    end
                end
                FWD_L1_MAC: begin
                    if (l1_rsp.mac_done) begin
                        l1_rn_q <= 1'b1;
                        state   <= FWD_L1_RN;
                    end
                end
                FWD_L1_RN: begin
                    if (l1_rsp.rn_done)
                        state <= FWD_L1_GOOD;
                end
                // Stalls here while the previous layer 1 entry is unread
                FWD_L1_GOOD: begin
                    if (l1_good_go) begin
                        l2_mac_q <= 1'b1;
                        state    <= FWD_L2_MAC;
                    end
                end
                FWD_L2_MAC: begin
                    if (l2_rsp.mac_done) begin
                        l2_rn_q <= 1'b1;
                        state   <= FWD_L2_RN;
                    end
                end
                FWD_L2_RN: begin
                    if (l2_rsp.rn_done) begin
                        l2_good_sent <= 1'b0;
                        state        <= FWD_L2_GOOD;
                    end
                end
                FWD_L2_GOOD: begin
                    if (l2_good_go)
                        l2_good_sent <= 1'b1;
                    if (l2_good_sent && l2_rsp.goodness_done)
                        state <= FWD_NEXT_PASS;
                end
                // Negative pass of the same sample, or the next sample
                FWD_NEXT_PASS: begin
                    if (is_positive) begin
                        is_positive <= 1'b0;
                        load_start  <= 1'b1;
                        state       <= FWD_LOAD;
                    end else if (sample_idx == sample_idx_t'(NUM_SAMPLES - 1)) begin
                        state <= FWD_DONE;
                    end else begin
                        sample_idx  <= sample_idx + sample_idx_t'(1);
                        is_positive <= 1'b1;
                        load_start  <= 1'b1;
                        state       <= FWD_LOAD;
                    end
                end
                default: begin
                    // FWD_DONE rests until reset
                end
            endcase
        end
    end

    // Load, layer and goodness phases are strictly serial
    a_single_start: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({load_start, l1_req.mac_start, l1_req.rn_start, l1_req.goodness_start,
                  l2_req.mac_start, l2_req.rn_start, l2_req.goodness_start}));

endmodule

//--- logic/layer_mailbox.sv
//////////////////////////////
// Layer mailbox with one sticky entry and latched goodness
// per layer between the forward and update sequencers
//////////////////////////////
module layer_mailbox (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ff_train_pkg::layer_rsp_t l1_rsp,
    input  ff_train_pkg::layer_rsp_t l2_rsp,
    input  logic                     l1_ack,
    input  logic                     l2_ack,
    output logic                     l1_full,
    output logic                     l2_full,
    output ff_train_pkg::data_t      l1_goodness,
    output ff_train_pkg::data_t      l2_goodness
);
    import ff_train_pkg::*;

    // Index 0 is layer 1, index 1 is layer 2
    layer_rsp_t rsp  [2];
    logic       ack  [2];
    logic       full [2];
    data_t      good [2];

    assign rsp[0] = l1_rsp;
    assign rsp[1] = l2_rsp;
    assign ack[0] = l1_ack;
    assign ack[1] = l2_ack;

    assign l1_full     = full[0];
    assign l2_full     = full[1];
    assign l1_goodness = good[0];
    assign l2_goodness = good[1];

    for (genvar i = 0; i < 2; i++) begin : g_entry
        // Ack wins over a coincident done
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n)
                full[i] <= 1'b0;
            else if (ack[i])
                full[i] <= 1'b0;
            else if (rsp[i].goodness_done)
                full[i] <= 1'b1;
        end

        // Goodness latched whenever it arrives
        always_ff @(posedge clk) begin
            if (rsp[i].goodness_done)
                good[i] <= rsp[i].goodness_val;
        end

        // Forward side back-pressure keeps results from piling up
        a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
            rsp[i].goodness_done |-> !full[i]);
    end

endmodule

//--- logic/sample_loader.sv
//////////////////////////////
// Sample loader that streams one sample into the input buffer
// and then overwrites the first ten words with the pass label
//////////////////////////////
module sample_loader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_start,
    input  ff_train_pkg::sample_idx_t  sample_idx,
    input  logic                       is_positive,
    output ff_train_pkg::sample_addr_t sample_addr,
    output logic                       sample_en,
    input  ff_train_pkg::data_t        sample_rdata,
    output ff_train_pkg::sample_idx_t  label_addr,
    output logic                       label_en,
    input  ff_train_pkg::label_t       label_rdata,
    output ff_train_pkg::pixel_idx_t   inbuf_waddr,
    output logic                       inbuf_we,
    output ff_train_pkg::data_t        inbuf_wdata,
    output logic                       input_shadow_capture,
    output logic                       inject_en,
    output logic                       load_done,
    output ff_train_pkg::label_t       correct_label,
    output ff_train_pkg::label_t       injected_label
);
    import ff_train_pkg::*;

    // cnt holds the cycle number since load_start while busy
    logic         busy;
    load_cnt_t    cnt;
    logic         positive_q;
    sample_addr_t base;
    sample_addr_t start_addr;
    logic         pix_phase;
    load_cnt_t    waddr_full;
    label_t       label_word;
    label_t       wrong_label;
    logic         last;

    // First pixel of the requested sample
    assign start_addr = sample_addr_t'(sample_idx) * sample_addr_t'(INPUT_SIZE);

    // Reads, pixel p goes out at cycle p, label at cycle 0
    assign sample_en   = load_start || (busy && cnt < load_cnt_t'(INPUT_SIZE));
    assign sample_addr = busy ? base + sample_addr_t'(cnt) : start_addr;
    assign label_en    = load_start;
    assign label_addr  = sample_idx;

    // Writes trail reads by one cycle, then ten label words follow
    assign pix_phase  = cnt <= load_cnt_t'(INPUT_SIZE);
    assign waddr_full = pix_phase ? cnt - load_cnt_t'(1) : cnt - load_cnt_t'(INPUT_SIZE + 1);
    assign label_word = label_t'(waddr_full);
    assign inbuf_we    = busy;
    assign inbuf_waddr = pixel_idx_t'(waddr_full);
    assign inbuf_wdata = pix_phase ? sample_rdata
                       : ((label_word == injected_label) ? LABEL_MAG : '0);

    // Negative pass uses the next class, 9 wraps to 0
    assign wrong_label = (label_rdata == label_t'(LABEL_PIXELS - 1))
                       ? '0 : label_rdata + label_t'(1);

    // Final label write closes the load
    assign last                 = busy && (cnt == load_cnt_t'(LOAD_LAST));
    assign input_shadow_capture = last;
    assign inject_en            = last;
    assign load_done            = last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy           <= 1'b0;
            cnt            <= '0;
            positive_q     <= 1'b1;
            correct_label  <= '0;
            injected_label <= '0;
        end else begin
            if (load_start) begin
                busy       <= 1'b1;
                cnt        <= load_cnt_t'(1);
                positive_q <= is_positive;
            end else if (last) begin
                busy <= 1'b0;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + load_cnt_t'(1);
            end
            // Label data lands one cycle after the cycle-0 read
            if (busy && cnt == load_cnt_t'(1)) begin
                correct_label  <= label_rdata;
                injected_label <= positive_q ? label_rdata : wrong_label;
            end
        end
    end

    // Sample base address
    always_ff @(posedge clk) begin
        if (load_start)
            base <= start_addr;
    end

    // Pixel and label phases never reach past the buffer
    a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
        inbuf_we |-> waddr_full < load_cnt_t'(INPUT_SIZE));

endmodule

//--- logic/training_controller.sv
//////////////////////////////
// Forward-Forward training controller top
//////////////////////////////
module training_controller (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    output logic                       training_done,
    output ff_train_pkg::sample_addr_t sample_addr,
    output logic                       sample_en,
    input  ff_train_pkg::data_t        sample_rdata,
    output ff_train_pkg::sample_idx_t  label_addr,
    output logic                       label_en,
    input  ff_train_pkg::label_t       label_rdata,
    output ff_train_pkg::pixel_idx_t   inbuf_waddr,
    output logic                       inbuf_we,
    output ff_train_pkg::data_t        inbuf_wdata,
    output ff_train_pkg::label_t       correct_label,
    output ff_train_pkg::label_t       injected_label,
    output logic                       input_shadow_capture,
    output logic                       inject_en,
    output ff_train_pkg::layer_req_t   l1_req,
    output ff_train_pkg::layer_req_t   l2_req,
    input  ff_train_pkg::layer_rsp_t   l1_rsp,
    input  ff_train_pkg::layer_rsp_t   l2_rsp,
    output ff_train_pkg::pe_cmd_t      pe_cmd,
    input  logic                       pe_done
);
    import ff_train_pkg::*;

    // Forward sequencer to sample loader
    logic        load_start;
    sample_idx_t sample_idx;
    logic        is_positive;
    logic        load_done;

    // Mailbox between the forward and update sides
    logic        l1_full;
    logic        l2_full;
    data_t       l1_goodness;
    data_t       l2_goodness;
    logic        l1_ack;
    logic        l2_ack;

    sample_loader u_loader (.*);

    forward_sequencer u_forward (.*);

    layer_mailbox u_mailbox (.*);

    update_sequencer u_update (.*);

endmodule

//--- logic/update_sequencer.sv
//////////////////////////////
// Update sequencer issuing plasticity commands per layer
// and pass in fixed order, then signalling completion
//////////////////////////////
module update_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  l1_full,
    input  logic                  l2_full,
    input  ff_train_pkg::data_t   l1_goodness,
    input  ff_train_pkg::data_t   l2_goodness,
    output logic                  l1_ack,
    output logic                  l2_ack,
    output ff_train_pkg::pe_cmd_t pe_cmd,
    input  logic                  pe_done,
    output logic                  training_done
);
    import ff_train_pkg::*;

    upd_state_t  state;

    // Own position in the dataset, independent of the forward side
    sample_idx_t sample;
    logic        positive;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= UPD_IDLE;
            sample        <= '0;
            positive      <= 1'b1;
            l1_ack        <= 1'b0;
            l2_ack        <= 1'b0;
            pe_cmd        <= '0;
            training_done <= 1'b0;
        end else begin
            l1_ack        <= 1'b0;
            l2_ack        <= 1'b0;
            pe_cmd.start  <= 1'b0;
            training_done <= 1'b0;
            case (state)
                UPD_IDLE: begin
                    if (start) begin
                        sample   <= '0;
                        positive <= 1'b1;
                        state    <= UPD_WAIT_L1;
                    end
                end
                // Command and ack go out the cycle after full is seen
                UPD_WAIT_L1: begin
                    if (l1_full) begin
                        pe_cmd <= '{start:       1'b1,
                                    layer_sel:   1'b0,
                                    is_positive: positive,
                                    goodness:    l1_goodness};
                        l1_ack <= 1'b1;
                        state  <= UPD_PE_L1;
                    end
                end
                UPD_PE_L1: begin
                    if (pe_done)
                        state <= UPD_WAIT_L2;
                end
                UPD_WAIT_L2: begin
                    if (l2_full) begin
                        pe_cmd <= '{start:       1'b1,
                                    layer_sel:   1'b1,
                                    is_positive: positive,
                                    goodness:    l2_goodness};
                        l2_ack <= 1'b1;
                        state  <= UPD_PE_L2;
                    end
                end
                UPD_PE_L2: begin
                    if (pe_done)
                        state <= UPD_NEXT;
                end
                // Negative pass of the same sample, the next sample, or finish
                UPD_NEXT: begin
                    if (positive) begin
                        positive <= 1'b0;
                        state    <= UPD_WAIT_L1;
                    end else if (sample == sample_idx_t'(NUM_SAMPLES - 1)) begin
                        training_done <= 1'b1;
                        state         <= UPD_DONE;
                    end else begin
                        sample   <= sample + sample_idx_t'(1);
                        positive <= 1'b1;
                        state    <= UPD_WAIT_L1;
                    end
                end
                default: begin
                    // UPD_DONE rests until reset
                end
            endcase
        end
    end

    // An ack only ever consumes a full entry
    a_l1_ack_full: assert property (@(posedge clk) disable iff (!rst_n)
        l1_ack |-> l1_full);
    a_l2_ack_full: assert property (@(posedge clk) disable iff (!rst_n)
        l2_ack |-> l2_full);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the training controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_training_controller -f all.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi
